// File: clk_rst_top.f
rtl/clk_rst_pkg.sv
rtl/clk_rst_cmd_decoder.sv
rtl/clk_rst_sequencer.sv
rtl/synchronizer_asr.sv
rtl/cluster_header.sv
rtl/clk_rst_top.sv
tb/tb_clk_gen.sv
tb/clk_rst_checker.sv
tb/tb_clk_rst_top.sv

// File: rtl/clk_rst_cmd_decoder.sv
// --------------------------------------
// Command input stage with a one-entry register
// Feeds legal commands to the sequencer over valid/ready
// --------------------------------------
`timescale 1ns/1ps

module clk_rst_cmd_decoder (
   input  logic                              gclk,
   input  logic                              rst_n,
   input  logic                              cmd_valid,
   output logic                              cmd_ready,
   input  clk_rst_pkg::cmd_op_e              cmd_op,
   input  logic [clk_rst_pkg::CLUSTER_W-1:0] cmd_cluster,
   output logic                              req_valid,
   input  logic                              req_ready,
   output clk_rst_pkg::cmd_op_e              req_op,
   output logic [clk_rst_pkg::CLUSTER_W-1:0] req_cluster
);
   import clk_rst_pkg::*;

   logic cmd_take;
   logic req_take;
   logic cmd_legal;

   // Only the five defined opcodes are forwarded
   function automatic logic op_is_legal(input cmd_op_e op);
      logic legal;
      case (op)
         CMD_CLK_ON,
         CMD_CLK_OFF,
         CMD_RST_ASSERT,
         CMD_RST_RELEASE,
         CMD_DBG_INIT: legal = 1'b1;
         default:      legal = 1'b0;
      endcase
      return legal;
   endfunction

   // Ready means the register is empty, so one command is in flight at most
   assign cmd_ready = ~req_valid;
   assign cmd_take  = cmd_valid & cmd_ready;
   assign req_take  = req_valid & req_ready;
   assign cmd_legal = op_is_legal(cmd_op);

   // Full flag doubles as req_valid
   always_ff @(posedge gclk or negedge rst_n) begin
      if (!rst_n) begin
         req_valid <= 1'b0;
      end else if (cmd_take) begin
         // Undefined opcode is consumed here and never reaches the sequencer
         req_valid <= cmd_legal;
      end else if (req_take) begin
         req_valid <= 1'b0;
      end
   end

   // Command payload, loaded only when a legal command is taken
   always_ff @(posedge gclk) begin
      if (cmd_take && cmd_legal) begin
         req_op      <= cmd_op;
         req_cluster <= cmd_cluster;
      end
   end

endmodule

// File: rtl/clk_rst_pkg.sv
// --------------------------------------
// Shared constants and types for the cluster clock and reset block
// Compiled first, used by decoder, sequencer and top level
// --------------------------------------
package clk_rst_pkg;

   // Cluster count and index width
   localparam int NUM_CLUSTERS = 4;
   localparam int CLUSTER_W    = 2;

   // Sequence delays in gclk cycles
   localparam int RST_WAIT_CYCLES  = 8;
   localparam int DBG_PULSE_CYCLES = 4;

   // Down-counter must hold the longer of the two delays
   localparam int SEQ_CNT_MAX = (RST_WAIT_CYCLES > DBG_PULSE_CYCLES) ?
                                RST_WAIT_CYCLES : DBG_PULSE_CYCLES;
   localparam int SEQ_CNT_W   = $clog2(SEQ_CNT_MAX + 1);

   // Commands from the system controller
   typedef enum logic [2:0] {
      CMD_CLK_ON      = 3'd0,
      CMD_CLK_OFF     = 3'd1,
      CMD_RST_ASSERT  = 3'd2,
      CMD_RST_RELEASE = 3'd3,
      CMD_DBG_INIT    = 3'd4
   } cmd_op_e;

   // Reset and debug-init sequencer states
   typedef enum logic [2:0] {
      SEQ_IDLE      = 3'd0,
      // Global reset held low, clocks may still be switched
      SEQ_RST_HOLD  = 3'd1,
      // Counting down to reset release
      SEQ_RST_WAIT  = 3'd2,
      // Debug-init line held low
      SEQ_DBG_PULSE = 3'd3
   } seq_state_e;

endpackage

// File: rtl/clk_rst_sequencer.sv
// --------------------------------------
// Cluster enable register and reset / debug-init FSM
// Sole source of the global grst_l and gdbginit_l levels
// --------------------------------------
`timescale 1ns/1ps

module clk_rst_sequencer (
   input  logic                                 gclk,
   input  logic                                 rst_n,
   input  logic                                 req_valid,
   output logic                                 req_ready,
   input  clk_rst_pkg::cmd_op_e                 req_op,
   input  logic [clk_rst_pkg::CLUSTER_W-1:0]    req_cluster,
   output logic [clk_rst_pkg::NUM_CLUSTERS-1:0] cluster_cken,
   output logic                                 grst_l,
   output logic                                 gdbginit_l
);
   import clk_rst_pkg::*;

   seq_state_e           state;
   logic [SEQ_CNT_W-1:0] cnt;
   logic                 req_take;
   logic                 in_hold;

   // Busy only while a timed sequence runs
   // HOLD still takes requests so clocks and release can be issued
   assign req_ready = (state == SEQ_IDLE) || (state == SEQ_RST_HOLD);
   assign req_take  = req_valid & req_ready;
   assign in_hold   = (state == SEQ_RST_HOLD);

   always_ff @(posedge gclk or negedge rst_n) begin
      if (!rst_n) begin
         state        <= SEQ_IDLE;
         cnt          <= '0;
         cluster_cken <= '0;
         // Global reset stays low until the first release sequence
         grst_l       <= 1'b0;
         gdbginit_l   <= 1'b0;
      end else begin
         // Debug-init idles high, overridden below when a pulse starts
         if (state != SEQ_DBG_PULSE) begin
            gdbginit_l <= 1'b1;
         end

         case (state)
            SEQ_IDLE,
            SEQ_RST_HOLD: begin
               if (req_take) begin
                  case (req_op)
                     CMD_CLK_ON: begin
                        cluster_cken[req_cluster] <= 1'b1;
                     end
                     CMD_CLK_OFF: begin
                        cluster_cken[req_cluster] <= 1'b0;
                     end
                     CMD_RST_ASSERT: begin
                        // Repeated assert while holding has no effect
                        if (!in_hold) begin
                           grst_l <= 1'b0;
                           state  <= SEQ_RST_HOLD;
                        end
                     end
                     CMD_RST_RELEASE: begin
                        state <= SEQ_RST_WAIT;
                        cnt   <= SEQ_CNT_W'(RST_WAIT_CYCLES);
                     end
                     CMD_DBG_INIT: begin
                        // Debug init is not run while reset is held
                        if (!in_hold) begin
                           gdbginit_l <= 1'b0;
                           state      <= SEQ_DBG_PULSE;
                           cnt        <= SEQ_CNT_W'(DBG_PULSE_CYCLES);
                        end
                     end
                     default: begin
                        cnt <= cnt;
                     end
                  endcase
               end
            end

            SEQ_RST_WAIT: begin
               cnt <= cnt - 1'b1;
               // Last wait cycle, release the global reset
               if (cnt == SEQ_CNT_W'(1)) begin
                  grst_l <= 1'b1;
                  state  <= SEQ_IDLE;
               end
            end

            SEQ_DBG_PULSE: begin
               cnt <= cnt - 1'b1;
               // End of pulse, line goes back high
               if (cnt == SEQ_CNT_W'(1)) begin
                  gdbginit_l <= 1'b1;
                  state      <= SEQ_IDLE;
               end
            end

            default: begin
               state <= SEQ_IDLE;
            end
         endcase
      end
   end

endmodule

// File: rtl/clk_rst_top.sv
// --------------------------------------
// Cluster clock and reset distribution top level
// Decoder, sequencer and one header per cluster
// --------------------------------------
`timescale 1ns/1ps

module clk_rst_top (
   input  logic                                 gclk,
   input  logic                                 rst_n,
   input  logic                                 cmd_valid,
   output logic                                 cmd_ready,
   input  clk_rst_pkg::cmd_op_e                 cmd_op,
   input  logic [clk_rst_pkg::CLUSTER_W-1:0]    cmd_cluster,
   output logic [clk_rst_pkg::NUM_CLUSTERS-1:0] rclk,
   output logic [clk_rst_pkg::NUM_CLUSTERS-1:0] cluster_grst_l,
   output logic [clk_rst_pkg::NUM_CLUSTERS-1:0] dbginit_l
);
   import clk_rst_pkg::*;

   // Decoder to sequencer
   logic                    req_valid;
   logic                    req_ready;
   cmd_op_e                 req_op;
   logic [CLUSTER_W-1:0]    req_cluster;

   // Sequencer to headers
   logic [NUM_CLUSTERS-1:0] cluster_cken;
   logic                    grst_l;
   logic                    gdbginit_l;

   // Asynchronous clears come straight from the chip reset
   logic                    arst_l;
   logic                    adbginit_l;

   assign arst_l     = rst_n;
   assign adbginit_l = rst_n;

   clk_rst_cmd_decoder u_decoder (
      .gclk        (gclk),
      .rst_n       (rst_n),
      .cmd_valid   (cmd_valid),
      .cmd_ready   (cmd_ready),
      .cmd_op      (cmd_op),
      .cmd_cluster (cmd_cluster),
      .req_valid   (req_valid),
      .req_ready   (req_ready),
      .req_op      (req_op),
      .req_cluster (req_cluster)
   );

   clk_rst_sequencer u_sequencer (
      .gclk         (gclk),
      .rst_n        (rst_n),
      .req_valid    (req_valid),
      .req_ready    (req_ready),
      .req_op       (req_op),
      .req_cluster  (req_cluster),
      .cluster_cken (cluster_cken),
      .grst_l       (grst_l),
      .gdbginit_l   (gdbginit_l)
   );

   // One clock header per cluster
   for (genvar i = 0; i < NUM_CLUSTERS; i++) begin : g_cluster
      cluster_header u_header (
         .gclk           (gclk),
         .cluster_cken   (cluster_cken[i]),
         .arst_l         (arst_l),
         .grst_l         (grst_l),
         .adbginit_l     (adbginit_l),
         .gdbginit_l     (gdbginit_l),
         .rclk           (rclk[i]),
         .cluster_grst_l (cluster_grst_l[i]),
         .dbginit_l      (dbginit_l[i])
      );
   end

endmodule

// File: rtl/cluster_header.sv
// --------------------------------------
// Per-cluster clock gate and reset / debug-init repeaters
// One instance per cluster under the top level
// --------------------------------------
`timescale 1ns/1ps

module cluster_header (
   input  logic gclk,
   input  logic cluster_cken,
   input  logic arst_l,
   input  logic grst_l,
   input  logic adbginit_l,
   input  logic gdbginit_l,
   output logic rclk,
   output logic cluster_grst_l,
   output logic dbginit_l
);

   logic pre_sync_enable;
   logic sync_enable;

   // Enable master stage on the rising gclk edge
   always_ff @(posedge gclk or negedge arst_l) begin
      if (!arst_l) begin
         pre_sync_enable <= 1'b0;
      end else begin
         pre_sync_enable <= cluster_cken;
      end
   end

   // Slave latch, open while gclk is low
   // Keeps the enable stable during the high phase so rclk has no glitch
   always_latch begin
      if (!arst_l) begin
         sync_enable <= 1'b0;
      end else if (!gclk) begin
         sync_enable <= pre_sync_enable;
      end
   end

   // Gated cluster clock
   assign rclk = gclk & sync_enable;

   // Global reset repeater
   synchronizer_asr rst_repeater (
      .gclk     (gclk),
      .rclk     (rclk),
      .arst_l   (arst_l),
      .async_in (grst_l),
      .sync_out (cluster_grst_l)
   );

   // Debug-init repeater, cleared by its own async line
   synchronizer_asr dbginit_repeater (
      .gclk     (gclk),
      .rclk     (rclk),
      .arst_l   (adbginit_l),
      .async_in (gdbginit_l),
      .sync_out (dbginit_l)
   );

endmodule

// File: rtl/synchronizer_asr.sv
// --------------------------------------
// Two-flop repeater for an active-low level
// First stage on gclk, second on the gated rclk
// --------------------------------------
`timescale 1ns/1ps

module synchronizer_asr (
   input  logic gclk,
   input  logic rclk,
   input  logic arst_l,
   input  logic async_in,
   output logic sync_out
);

   logic stage1;

   // Capture on the free-running clock
   always_ff @(posedge gclk or negedge arst_l) begin
      if (!arst_l) begin
         stage1 <= 1'b0;
      end else begin
         stage1 <= async_in;
      end
   end

   // Output stage only moves while the cluster clock runs
   // Holds its last level when rclk is gated off
   always_ff @(posedge rclk or negedge arst_l) begin
      if (!arst_l) begin
         sync_out <= 1'b0;
      end else begin
         sync_out <= stage1;
      end
   end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the clk_rst_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module tb_clk_rst_top \
   -f clk_rst_top.f \
   -o sim_clk_rst_top
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "Verilator build failed with status $build_status"
   exit 1
fi

# Keep running after an assertion error so the testbench can report it
sim_output=$(./obj_dir/sim_clk_rst_top +verilator+error+limit+1000 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_output" | grep -q "All tests passed!"; then
   exit 0
else
   exit 1
fi

// File: tb/clk_rst_checker.sv
// --------------------------------------
// Handshake and reset-ordering assertions, bound into clk_rst_top
// --------------------------------------
`timescale 1ns/1ps

module clk_rst_checker (
   input  logic                                 gclk,
   input  logic                                 rst_n,
   input  logic                                 cmd_valid,
   input  logic                                 cmd_ready,
   input  clk_rst_pkg::cmd_op_e                 cmd_op,
   input  logic [clk_rst_pkg::NUM_CLUSTERS-1:0] rclk,
   input  logic [clk_rst_pkg::NUM_CLUSTERS-1:0] cluster_grst_l
);
   import clk_rst_pkg::*;

   logic clk_on_seen;
   int   hold_fails = 0;
   int   gate_fails = 0;
   int   rise_fails = 0;
   int   fail_count;

   assign fail_count = hold_fails + gate_fails + rise_fails;

   // Set once the first CLK_ON has been taken by the decoder
   always_ff @(posedge gclk or negedge rst_n) begin
      if (!rst_n) begin
         clk_on_seen <= 1'b0;
      end else if (cmd_valid && cmd_ready && cmd_op == CMD_CLK_ON) begin
         clk_on_seen <= 1'b1;
      end
   end

   // Sender keeps its opcode while stalled
   cmd_hold_stable: assert property (@(posedge gclk) disable iff (!rst_n)
      (cmd_valid && !cmd_ready) |=> $stable(cmd_op))
   else begin
      hold_fails++;
      $error("cmd_op changed while the command was stalled");
   end

   // Sampled on the falling edge, so rclk shows its high-phase level
   no_early_rclk: assert property (@(negedge gclk) disable iff (!rst_n)
      !clk_on_seen |-> (rclk == '0))
   else begin
      gate_fails++;
      $error("rclk pulsed before any CLK_ON was accepted");
   end

   // A rise of cluster_grst_l needs an rclk pulse in the same cycle
   grst_rise_gated: assert property (@(negedge gclk) disable iff (!rst_n)
      (cluster_grst_l & ~$past(cluster_grst_l) & ~rclk) == '0)
   else begin
      rise_fails++;
      $error("cluster_grst_l rose in a cycle with rclk gated off");
   end

endmodule

bind clk_rst_top clk_rst_checker u_checker (
   .gclk           (gclk),
   .rst_n          (rst_n),
   .cmd_valid      (cmd_valid),
   .cmd_ready      (cmd_ready),
   .cmd_op         (cmd_op),
   .rclk           (rclk),
   .cluster_grst_l (cluster_grst_l)
);

// File: tb/tb_clk_gen.sv
// --------------------------------------
// Testbench clock and reset source
// --------------------------------------
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int PERIOD_NS  = 40,
   parameter int RST_CYCLES = 3
) (
   output logic gclk,
   output logic rst_n
);

   // Free-running gclk, starts low
   initial begin
      gclk = 1'b0;
      forever #(PERIOD_NS / 2) gclk = ~gclk;
   end

   // Reset held low for RST_CYCLES rising edges, released just after the last
   initial begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge gclk);
      #2;
      rst_n = 1'b1;
   end

endmodule

// File: tb/tb_clk_rst_top.sv
// --------------------------------------
// Testbench top with random commands against a cycle model of the block
// --------------------------------------
`timescale 1ns/1ps

module tb_clk_rst_top;
   import clk_rst_pkg::*;

   localparam int CLK_PERIOD      = 40;
   localparam int NUM_CMDS        = 120;
   localparam int DRAIN_CYCLES    = 24;
   localparam int CHECK_EVERY     = 16;
   localparam int WATCHDOG_CYCLES = NUM_CMDS * (RST_WAIT_CYCLES + 4) + 200;

   logic                    gclk;
   logic                    rst_n;
   logic                    cmd_valid;
   logic                    cmd_ready;
   cmd_op_e                 cmd_op;
   logic [CLUSTER_W-1:0]    cmd_cluster;
   logic [NUM_CLUSTERS-1:0] rclk;
   logic [NUM_CLUSTERS-1:0] cluster_grst_l;
   logic [NUM_CLUSTERS-1:0] dbginit_l;

   // Reference model state
   logic                    m_full;
   seq_state_e              m_state;
   int                      m_cnt;
   logic [NUM_CLUSTERS-1:0] m_cken;
   logic [NUM_CLUSTERS-1:0] m_pre;
   logic [NUM_CLUSTERS-1:0] m_en;
   logic [NUM_CLUSTERS-1:0] m_out_r;
   logic [NUM_CLUSTERS-1:0] m_out_d;
   logic                    m_grst;
   logic                    m_gdbg;
   logic                    m_st1_r;
   logic                    m_st1_d;
   logic [CLUSTER_W+2:0]    pending [$];
   logic                    accepted;
   int                      exp_edges [NUM_CLUSTERS];
   int                      edge_cnt  [NUM_CLUSTERS];

   logic [31:0]             rng;
   int                      sent;
   int                      stalls;
   int                      checks;
   int                      err_count;
   int                      cycle_no;

   tb_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RST_CYCLES(3)) u_clk_gen (
      .gclk  (gclk),
      .rst_n (rst_n)
   );

   clk_rst_top u_dut (
      .gclk           (gclk),
      .rst_n          (rst_n),
      .cmd_valid      (cmd_valid),
      .cmd_ready      (cmd_ready),
      .cmd_op         (cmd_op),
      .cmd_cluster    (cmd_cluster),
      .rclk           (rclk),
      .cluster_grst_l (cluster_grst_l),
      .dbginit_l      (dbginit_l)
   );

   // Count real rclk rising edges per cluster
   for (genvar g = 0; g < NUM_CLUSTERS; g++) begin : g_edges
      int count = 0;
      always @(posedge rclk[g]) begin
         count <= count + 1;
      end
      assign edge_cnt[g] = count;
   end

   function automatic logic [31:0] next_random(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Weighted toward CLK_ON so that reset levels reach the outputs
   // Code 7 stays undefined and must be dropped
   function automatic cmd_op_e pick_op(input logic [2:0] sel);
      cmd_op_e op;
      case (sel)
         3'd0, 3'd1, 3'd6: op = CMD_CLK_ON;
         3'd2:             op = CMD_CLK_OFF;
         3'd3:             op = CMD_RST_ASSERT;
         3'd4:             op = CMD_RST_RELEASE;
         3'd5:             op = CMD_DBG_INIT;
         default:          op = cmd_op_e'(3'd7);
      endcase
      return op;
   endfunction

   function automatic logic op_defined(input cmd_op_e op);
      return op inside {CMD_CLK_ON, CMD_CLK_OFF, CMD_RST_ASSERT, CMD_RST_RELEASE, CMD_DBG_INIT};
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      err_count++;
      $display("error %s: expected %0h actual %0h at %0d ns", name, exp, act, $time);
   endtask

   task automatic reset_model();
      m_full   = 1'b0;
      m_state  = SEQ_IDLE;
      m_cnt    = 0;
      m_cken   = '0;
      m_pre    = '0;
      m_en     = '0;
      m_out_r  = '0;
      m_out_d  = '0;
      m_grst   = 1'b0;
      m_gdbg   = 1'b0;
      m_st1_r  = 1'b0;
      m_st1_d  = 1'b0;
      accepted = 1'b0;
      pending.delete();
      for (int i = 0; i < NUM_CLUSTERS; i++) begin
         exp_edges[i] = 0;
      end
   endtask

   // One rising gclk edge where every right-hand side holds its value from before the edge
   task automatic step_model();
      logic                 seq_ready;
      logic                 take;
      logic [CLUSTER_W+2:0] entry;
      cmd_op_e              op;
      logic [CLUSTER_W-1:0] cl;
      seq_ready = (m_state == SEQ_IDLE) || (m_state == SEQ_RST_HOLD);
      take      = m_full && seq_ready;
      accepted  = cmd_valid && !m_full;
      if (cmd_valid && m_full) begin
         stalls++;
      end
      // Headers update first and the gate follows the enable two edges late
      m_en = m_pre;
      for (int i = 0; i < NUM_CLUSTERS; i++) begin
         if (m_en[i]) begin
            m_out_r[i] = m_st1_r;
            m_out_d[i] = m_st1_d;
            exp_edges[i]++;
         end
      end
      m_st1_r = m_grst;
      m_st1_d = m_gdbg;
      m_pre   = m_cken;
      // Sequencer
      if (m_state != SEQ_DBG_PULSE) begin
         m_gdbg = 1'b1;
      end
      case (m_state)
         SEQ_IDLE, SEQ_RST_HOLD: begin
            if (take) begin
               entry = pending.pop_front();
               op    = cmd_op_e'(entry[CLUSTER_W+:3]);
               cl    = entry[CLUSTER_W-1:0];
               case (op)
                  CMD_CLK_ON:  m_cken[cl] = 1'b1;
                  CMD_CLK_OFF: m_cken[cl] = 1'b0;
                  CMD_RST_ASSERT: begin
                     if (m_state == SEQ_IDLE) begin
                        m_grst  = 1'b0;
                        m_state = SEQ_RST_HOLD;
                     end
                  end
                  CMD_RST_RELEASE: begin
                     m_state = SEQ_RST_WAIT;
                     m_cnt   = RST_WAIT_CYCLES;
                  end
                  default: begin
                     // DBG_INIT is ignored while reset is held
                     if (m_state == SEQ_IDLE) begin
                        m_gdbg  = 1'b0;
                        m_state = SEQ_DBG_PULSE;
                        m_cnt   = DBG_PULSE_CYCLES;
                     end
                  end
               endcase
            end
         end
         SEQ_RST_WAIT: begin
            if (m_cnt == 1) begin
               m_grst  = 1'b1;
               m_state = SEQ_IDLE;
            end
            m_cnt = m_cnt - 1;
         end
         default: begin
            if (m_cnt == 1) begin
               m_gdbg  = 1'b1;
               m_state = SEQ_IDLE;
            end
            m_cnt = m_cnt - 1;
         end
      endcase
      // Decoder register stays empty after an undefined opcode
      if (accepted) begin
         m_full = op_defined(cmd_op);
         if (m_full) begin
            pending.push_back({3'(cmd_op), cmd_cluster});
         end
      end else if (take) begin
         m_full = 1'b0;
      end
   endtask

   // New command only when the previous one was taken
   task automatic drive_next();
      if (accepted) begin
         cmd_valid = 1'b0;
         sent++;
      end
      if (!cmd_valid && sent < NUM_CMDS) begin
         rng = next_random(rng);
         if (rng[3:2] != 2'b00) begin
            cmd_valid   = 1'b1;
            cmd_op      = pick_op(rng[10:8]);
            cmd_cluster = rng[17:16];
         end
      end
   endtask

   task automatic compare_outputs();
      checks += 5;
      assert (cmd_ready == !m_full)
         else report_mismatch("cmd_ready", !m_full, cmd_ready);
      assert (rclk == m_en)
         else report_mismatch("rclk gating", m_en, rclk);
      assert (cluster_grst_l == m_out_r)
         else report_mismatch("cluster_grst_l", m_out_r, cluster_grst_l);
      assert (dbginit_l == m_out_d)
         else report_mismatch("dbginit_l", m_out_d, dbginit_l);
      assert (u_dut.req_valid == m_full)
         else report_mismatch("req_valid", m_full, u_dut.req_valid);
      // Held request must be the oldest accepted command
      if (m_full) begin
         checks++;
         assert ({3'(u_dut.req_op), u_dut.req_cluster} == pending[0])
            else report_mismatch("queued command", pending[0],
                                 {3'(u_dut.req_op), u_dut.req_cluster});
      end
   endtask

   task automatic compare_edges();
      for (int i = 0; i < NUM_CLUSTERS; i++) begin
         checks++;
         assert (edge_cnt[i] == exp_edges[i])
            else report_mismatch($sformatf("rclk edge count %0d", i), exp_edges[i], edge_cnt[i]);
      end
   endtask

   // Model steps at the edge, inputs change at +2 ns, outputs compared in the high phase
   task automatic run_cycle();
      @(posedge gclk);
      step_model();
      #2;
      drive_next();
      #8;
      compare_outputs();
      cycle_no++;
      if (cycle_no % CHECK_EVERY == 0) begin
         compare_edges();
      end
   endtask

   initial begin
      #(CLK_PERIOD * WATCHDOG_CYCLES);
      $display("Timeout: run did not finish within %0d gclk cycles", WATCHDOG_CYCLES);
      $display("Test failures found");
      $finish;
   end

   initial begin
      cmd_valid   = 1'b0;
      cmd_op      = CMD_CLK_ON;
      cmd_cluster = '0;
      rng         = 32'd91334;
      sent        = 0;
      stalls      = 0;
      checks      = 0;
      err_count   = 0;
      cycle_no    = 0;
      reset_model();

      // Reset state sampled in the high phase while rst_n is low
      repeat (2) @(posedge gclk);
      #10;
      checks += 4;
      assert (cmd_ready == 1'b1) else report_mismatch("reset cmd_ready", 1, cmd_ready);
      assert (rclk == '0) else report_mismatch("reset rclk", 0, rclk);
      assert (cluster_grst_l == '0)
         else report_mismatch("reset cluster_grst_l", 0, cluster_grst_l);
      assert (dbginit_l == '0) else report_mismatch("reset dbginit_l", 0, dbginit_l);
      wait (rst_n);

      while (sent < NUM_CMDS) begin
         run_cycle();
      end
      repeat (DRAIN_CYCLES) run_cycle();
      compare_edges();

      $display("Summary: %0d checks, %0d cmds, %0d stalls, %0d mismatches, %0d assert fails",
               checks, sent, stalls, err_count, u_dut.u_checker.fail_count);
      if (err_count == 0 && u_dut.u_checker.fail_count == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule
